// ==== logic/exec_pkg.sv ====
package exec_pkg;

    localparam int width     = 32; // datapath width of the core.
    localparam int reg_idx_w = 5;

    // execute unit selected by the issue type field.
    typedef enum logic [3:0] {
        unit_alu    = 4'd0,
        unit_branch = 4'd1,
        unit_div    = 4'd2,
        unit_mem    = 4'd3
    } unit_e;

    // divide subtypes as carried in the pipeline subtype field.
    typedef enum logic [4:0] {
        div_w  = 5'd0, // signed quotient.
        mod_w  = 5'd1, // signed remainder.
        div_wu = 5'd2,
        mod_wu = 5'd3
    } div_op_e;

    typedef struct packed {
        unit_e                unit;
        div_op_e              op;
        logic [reg_idx_w-1:0] rd;
        logic [width-1:0]     din1; // dividend.
        logic [width-1:0]     din2; // divisor.
    } issue_t;

    // writeback toward the pipeline.
    typedef struct packed {
        logic                 valid;
        logic [reg_idx_w-1:0] rd;
        logic [width-1:0]     value;
    } result_t;

endpackage

// ==== logic/div_pkg.sv ====
package div_pkg;

    // divider FSM.
    typedef enum logic [1:0] {
        idle    = 2'd0,
        align   = 2'd1,
        iterate = 2'd2, // quotient bits and sign fix.
        finish  = 2'd3
    } div_state_e;

    // operand conditioning captured at issue and alignment.
    typedef struct packed {
        logic [5:0] shift;        // bit index of the next quotient step.
        logic       neg_dividend;
        logic       neg_divisor;
    } norm_t;

endpackage

// ==== logic/leading_one.sv ====
`timescale 1ns/1ps

module leading_one #(
    parameter int width = 32
) (
    input  logic [width-1:0]         din,
    output logic [$clog2(width)-1:0] pos,
    output logic                     any
);

    localparam int pos_w = $clog2(width);

    assign any = |din; // zero word has no leading one.

    // halve the window at each level and keep the half holding the top bit.
    always_comb
    begin
        logic [width-1:0] window;
        logic [width-1:0] upper;
        window = din;
        pos    = '0;
        for (int k = pos_w - 1; k >= 0; k--)
        begin
            upper = window >> (1 << k);
            if (|upper)
            begin
                pos[k] = 1'b1;
                window = upper;
            end
        end
    end

endmodule

// ==== logic/divider.sv ====
`timescale 1ns/1ps

module divider #(
    parameter int width = 32
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              flush,
    input  logic              start,
    input  exec_pkg::div_op_e op,
    input  logic [width-1:0]  din1,
    input  logic [width-1:0]  din2,
    output logic              busy,
    output logic              done,
    output logic [width-1:0]  quotient,
    output logic [width-1:0]  remainder
);

    localparam int pos_w = $clog2(width);

    div_pkg::div_state_e state;
    div_pkg::div_state_e state_nxt;
    div_pkg::norm_t      norm;
    div_pkg::norm_t      norm_nxt;

    logic [width-1:0] quo;      // shifts in one bit per step.
    logic [width-1:0] quo_nxt;
    logic [width-1:0] rem;      // working remainder.
    logic [width-1:0] rem_nxt;
    logic [width-1:0] dsr;      // divisor magnitude.
    logic [width-1:0] dsr_nxt;
    logic [pos_w-1:0] rem_pos;
    logic [pos_w-1:0] dsr_pos;
    logic             dsr_any;
    logic [5:0]       shift_calc;
    logic [width:0]   trial;
    logic             signed_op;

    function automatic logic [width-1:0] neg_if(
        input logic [width-1:0] value,
        input logic             neg
    );
        neg_if = neg ? -value : value;
    endfunction

    // ********************
    // operand alignment
    // ********************

    leading_one #(.width(width)) u_lo_rem (
        .din (rem),
        .pos (rem_pos),
        .any ()
    );

    leading_one #(.width(width)) u_lo_dsr (
        .din (dsr),
        .pos (dsr_pos),
        .any (dsr_any)
    );

    assign signed_op  = (op == exec_pkg::div_w) || (op == exec_pkg::mod_w);
    assign shift_calc = 6'(rem_pos) - 6'(dsr_pos); // negative when divisor is larger.
    assign trial      = {1'b0, rem} - {1'b0, dsr << norm.shift};

    // ********************
    // FSM
    // ********************

    always_comb
    begin
        state_nxt = state;
        norm_nxt  = norm;
        quo_nxt   = quo;
        rem_nxt   = rem;
        dsr_nxt   = dsr;
        unique case (state)
            div_pkg::idle:
            begin
                if (start)
                begin
                    norm_nxt.neg_dividend = signed_op & din1[width-1];
                    norm_nxt.neg_divisor  = signed_op & din2[width-1];
                    rem_nxt   = neg_if(din1, norm_nxt.neg_dividend);
                    dsr_nxt   = neg_if(din2, norm_nxt.neg_divisor);
                    state_nxt = div_pkg::align;
                end
            end
            div_pkg::align:
            begin
                norm_nxt.shift = shift_calc;
                quo_nxt        = '0;
                if (!dsr_any || shift_calc[5])
                begin
                    // early out returns the dividend as remainder.
                    rem_nxt   = neg_if(rem, norm.neg_dividend);
                    state_nxt = div_pkg::finish;
                end
                else
                begin
                    state_nxt = div_pkg::iterate;
                end
            end
            div_pkg::iterate:
            begin
                if (norm.shift[5])
                begin
                    // all bits done. restore the signs.
                    quo_nxt   = neg_if(quo, norm.neg_dividend ^ norm.neg_divisor);
                    rem_nxt   = neg_if(rem, norm.neg_dividend);
                    state_nxt = div_pkg::finish;
                end
                else
                begin
                    quo_nxt        = {quo[width-2:0], ~trial[width]};
                    norm_nxt.shift = norm.shift - 6'd1;
                    if (!trial[width])
                    begin
                        rem_nxt = trial[width-1:0]; // subtraction fits.
                    end
                end
            end
            default:
            begin
                state_nxt = div_pkg::idle; // finish lasts one cycle.
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state <= div_pkg::idle;
            norm  <= '0;
        end
        else if (flush)
        begin
            state <= div_pkg::idle; // abort.
            norm  <= '0;
        end
        else
        begin
            state <= state_nxt;
            norm  <= norm_nxt;
        end
    end

    always_ff @(posedge clk)
    begin
        quo <= quo_nxt;
        rem <= rem_nxt;
        dsr <= dsr_nxt;
    end

    assign busy      = (state != div_pkg::idle);
    assign done      = (state == div_pkg::finish);
    assign quotient  = quo;
    assign remainder = rem;

endmodule

// ==== logic/div_result_stage.sv ====
`timescale 1ns/1ps

module div_result_stage (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           flush,
    input  logic                           stall,
    input  logic                           done,
    input  exec_pkg::div_op_e              op,
    input  logic [exec_pkg::reg_idx_w-1:0] rd,
    input  logic [exec_pkg::width-1:0]     quotient,
    input  logic [exec_pkg::width-1:0]     remainder,
    output logic                           pending,
    output exec_pkg::result_t              result
);

    logic                           valid_q;
    logic [exec_pkg::reg_idx_w-1:0] rd_q;
    logic [exec_pkg::width-1:0]     value_q;
    logic                           want_quo;

    assign want_quo = (op == exec_pkg::div_w) || (op == exec_pkg::div_wu);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            valid_q <= 1'b0;
        else if (flush)
            valid_q <= 1'b0;
        else if (done)
            valid_q <= 1'b1;
        else if (!stall)
            valid_q <= 1'b0; // taken downstream.
    end

    always_ff @(posedge clk)
    begin
        if (done)
        begin
            rd_q    <= rd;
            value_q <= want_quo ? quotient : remainder;
        end
    end

    // held result keeps the unit busy.
    assign pending = valid_q & stall;

    assign result = '{valid: valid_q, rd: rd_q, value: value_q};

endmodule

// ==== logic/div_unit_top.sv ====
`timescale 1ns/1ps

module div_unit_top #(
    parameter int width = 32
) (
    input  logic              clk,
    input  logic              arst_n,
    input  exec_pkg::issue_t  issue,
    input  logic              stall,
    input  logic              flush,
    output logic              busy,
    output exec_pkg::result_t result
);

    logic                           accept;
    logic                           div_busy;
    logic                           div_done;
    logic                           pending;
    logic [width-1:0]               quotient;
    logic [width-1:0]               remainder;
    exec_pkg::div_op_e              op_q;
    logic [exec_pkg::reg_idx_w-1:0] rd_q;

    // packed structs are sized for the package width.
    if (width != exec_pkg::width)
    begin : g_width_check
        $error("div_unit_top width does not match exec_pkg::width");
    end

    // ********************
    // issue decode
    // ********************

    assign accept = (issue.unit == exec_pkg::unit_div) && !stall && !busy;

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            op_q <= issue.op; // kept until writeback.
            rd_q <= issue.rd;
        end
    end

    divider #(.width(width)) u_divider (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (flush),
        .start     (accept),
        .op        (issue.op),
        .din1      (issue.din1),
        .din2      (issue.din2),
        .busy      (div_busy),
        .done      (div_done),
        .quotient  (quotient),
        .remainder (remainder)
    );

    div_result_stage u_result (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (flush),
        .stall     (stall),
        .done      (div_done),
        .op        (op_q),
        .rd        (rd_q),
        .quotient  (quotient),
        .remainder (remainder),
        .pending   (pending),
        .result    (result)
    );

    assign busy = div_busy | pending;

endmodule

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int period_ns    = 4,
    parameter int reset_cycles = 3
) (
    output logic clk,
    output logic arst_n
);

    initial
    begin
        clk    = 1'b0;
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1; // release away from the active edge.
    end

    always #(period_ns / 2.0) clk = ~clk;

endmodule

// ==== tb/tb_div_unit.sv ====
`timescale 1ns/1ps

module tb_div_unit;

    localparam int n_random     = 200;
    localparam int n_requests   = n_random + 40;
    localparam int result_limit = 45; // longest latency plus slack.
    localparam int max_cycles   = n_requests * result_limit + 300;

    logic              clk;
    logic              arst_n;
    exec_pkg::issue_t  issue;
    logic              stall;
    logic              flush;
    logic              busy;
    exec_pkg::result_t result;
    logic              accepted;

    logic [31:0] exp_value;
    logic [4:0]  exp_rd;
    logic        exp_armed; // a result is owed to the pipeline.
    integer      seed;
    int          errors;
    int          tests;
    int          failed;

    // directed operands. first four are the zero-quotient cases, last four the sign cases.
    logic [31:0] dir_a [8] = '{32'd5, 32'hffff_fffd, 32'd77, 32'h8765_4321,
                               32'hffff_ff9c, 32'd100, 32'hffff_ff9c, 32'h8000_0000};
    logic [31:0] dir_b [8] = '{32'd9, 32'd100, 32'd0, 32'd0,
                               32'd7, 32'hffff_fff9, 32'hffff_fff9, 32'hffff_ffff};

    tb_clock_gen u_clk_gen (.clk(clk), .arst_n(arst_n));

    div_unit_top #(.width(32)) dut_i (
        .clk    (clk),
        .arst_n (arst_n),
        .issue  (issue),
        .stall  (stall),
        .flush  (flush),
        .busy   (busy),
        .result (result)
    );

    assign accepted = (issue.unit == exec_pkg::unit_div) && !stall && !busy;

    function automatic logic [31:0] model(input exec_pkg::div_op_e op,
                                          input logic [31:0] a, input logic [31:0] b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic [31:0]        q;
        logic [31:0]        r;
        sa = a;
        sb = b;
        if (b == '0)
        begin
            q = '0;
            r = a;
        end
        else if (op == exec_pkg::div_wu || op == exec_pkg::mod_wu)
        begin
            q = a / b;
            r = a % b;
        end
        else if (a == 32'h8000_0000 && b == 32'hffff_ffff)
        begin
            q = a; // wraps.
            r = '0;
        end
        else
        begin
            q = sa / sb;
            r = sa % sb;
        end
        return (op == exec_pkg::div_w || op == exec_pkg::div_wu) ? q : r;
    endfunction

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] want);
        errors++;
        $display("error t=%0t %s got %h expected %h", $time, name, got, want);
    endtask

    task automatic report_fault(input string what);
        errors++;
        $display("t=%0t %s", $time, what);
    endtask

    // ********************
    // assertions
    // ********************

    a_value : assert property (@(posedge clk) disable iff (!arst_n)
        result.valid |-> result.value == exp_value)
        else report_value("result.value", $sampled(result.value), $sampled(exp_value));
    a_rd : assert property (@(posedge clk) disable iff (!arst_n)
        result.valid |-> result.rd == exp_rd)
        else report_value("result.rd", $sampled(result.rd), $sampled(exp_rd));
    a_owed : assert property (@(posedge clk) disable iff (!arst_n)
        result.valid |-> exp_armed)
        else report_fault("result valid with no request outstanding");
    a_busy_rise : assert property (@(posedge clk) disable iff (!arst_n)
        accepted && !flush |=> busy)
        else report_fault("busy did not rise after an accepted request");
    a_spacing : assert property (@(posedge clk) disable iff (!arst_n)
        dut_i.div_done && !flush |=> result.valid)
        else report_fault("result valid did not follow done by one cycle");
    a_origin : assert property (@(posedge clk) disable iff (!arst_n)
        $rose(result.valid) |-> $past(dut_i.div_done))
        else report_fault("result valid rose without done in the cycle before");
    a_hold : assert property (@(posedge clk) disable iff (!arst_n)
        result.valid && stall && !flush |=> result.valid && $stable(result.value))
        else report_fault("held result dropped or changed under stall");
    a_held_busy : assert property (@(posedge clk) disable iff (!arst_n)
        result.valid && stall |-> busy)
        else report_fault("busy low while a result is held");
    a_flush : assert property (@(posedge clk) disable iff (!arst_n)
        flush |=> !busy)
        else report_fault("unit still busy after flush");

    // ********************
    // stimulus
    // ********************

    task automatic issue_request(input exec_pkg::div_op_e op, input logic [31:0] a,
                                 input logic [31:0] b, input logic [4:0] rd);
        int waited;
        waited = 0;
        @(negedge clk);
        while (busy && waited < result_limit)
        begin
            @(negedge clk);
            waited++;
        end
        if (busy)
            report_fault("unit never became free to take a request");
        issue     = '{unit: exec_pkg::unit_div, op: op, rd: rd, din1: a, din2: b};
        exp_value = model(op, a, b);
        exp_rd    = rd;
        exp_armed = 1'b1;
        @(negedge clk);
        issue.unit = exec_pkg::unit_alu;
    endtask

    task automatic wait_result(input logic need_take);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!(result.valid && !(need_take && stall)) && waited < result_limit)
        begin
            @(negedge clk);
            waited++;
        end
        if (!result.valid)
            report_fault("no result valid within the expected latency");
    endtask

    task automatic run_request(input exec_pkg::div_op_e op, input logic [31:0] a,
                               input logic [31:0] b, input logic [4:0] rd);
        issue_request(op, a, b, rd);
        wait_result(1'b1);
        @(negedge clk); // taken at the edge before.
        exp_armed = 1'b0;
    endtask

    task automatic finish_test(input string name, input int mark);
        tests++;
        if (errors != mark)
        begin
            failed++;
            $display("test %s: FAIL, %0d errors", name, errors - mark);
        end
        else
            $display("test %s: pass", name);
    endtask

    initial
    begin
        logic [31:0] a;
        logic [31:0] b;
        int          mark;
        issue     = '0; // idle bus selects the alu.
        stall     = 1'b0;
        flush     = 1'b0;
        exp_value = '0;
        exp_rd    = '0;
        exp_armed = 1'b0;
        errors    = 0;
        tests     = 0;
        failed    = 0;
        seed      = 32'ha9d9_f9c3;
        wait (arst_n);

        mark = errors;
        for (int n = 0; n < n_random; n++)
        begin
            a = $random(seed);
            b = $random(seed);
            b = b >> ($random(seed) & 31); // spread the quotient lengths.
            if (n % 25 == 7)
                b = '0;
            run_request(exec_pkg::div_op_e'(5'($random(seed) & 3)), a, b, 5'(n));
        end
        finish_test("random operands", mark);

        mark = errors;
        for (int i = 0; i < 4; i++)
            for (int k = 0; k < 4; k++)
                run_request(exec_pkg::div_op_e'(5'(k)), dir_a[i], dir_b[i], 5'(i + 1));
        finish_test("zero quotient and zero divisor", mark);

        mark = errors;
        for (int i = 4; i < 8; i++)
            for (int k = 0; k < 4; k++)
                run_request(exec_pkg::div_op_e'(5'(k)), dir_a[i], dir_b[i], 5'(i + 1));
        finish_test("operand signs", mark);

        mark = errors;
        issue_request(exec_pkg::div_wu, 32'hffff_ffff, 32'd3, 5'd9);
        repeat (4) @(negedge clk);
        exp_armed = 1'b0;
        flush     = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        repeat (result_limit) @(negedge clk);
        run_request(exec_pkg::mod_w, 32'hffff_f000, 32'd7, 5'd10);
        finish_test("flush", mark);

        mark = errors;
        issue_request(exec_pkg::div_w, 32'hffff_fc00, 32'd13, 5'd11);
        stall = 1'b1;
        wait_result(1'b0);
        repeat (6) @(negedge clk);
        stall = 1'b0;
        @(negedge clk);
        exp_armed = 1'b0;
        finish_test("downstream stall", mark);

        mark = errors;
        issue = '{unit: exec_pkg::unit_mem, op: exec_pkg::div_w, rd: 5'd12,
                  din1: 32'd50, din2: 32'd5};
        repeat (8) @(negedge clk);
        issue.unit = exec_pkg::unit_div;
        stall      = 1'b1;
        repeat (8) @(negedge clk);
        issue.unit = exec_pkg::unit_alu;
        stall      = 1'b0;
        repeat (result_limit) @(negedge clk);
        finish_test("ignored requests", mark);

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

    initial
    begin
        repeat (max_cycles) @(posedge clk);
        $display("watchdog stopped the run after %0d cycles", max_cycles);
        $display("Something failed");
        $finish;
    end

endmodule

// ==== compile.f ====
logic/exec_pkg.sv
logic/div_pkg.sv
logic/leading_one.sv
logic/divider.sv
logic/div_result_stage.sv
logic/div_unit_top.sv
tb/tb_clock_gen.sv
tb/tb_div_unit.sv

// ==== Bender.yml ====
package:
  name: div_unit

sources:
  - files:
      - logic/exec_pkg.sv
      - logic/div_pkg.sv
      - logic/leading_one.sv
      - logic/divider.sv
      - logic/div_result_stage.sv
      - logic/div_unit_top.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/tb_div_unit.sv
